// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= lsfUnitTb
FLIST ?= vlog.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert
RUN_ARGS ?= +verilator+error+limit+1000

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FLIST)

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS) | tee $(LOG)
	@if grep -qF '*** FAILED ***' $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -qF '*** PASSED ***' $(LOG) || (echo "simulation did not finish"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== common/lsfPkg.sv ====
`default_nettype none

package lsfPkg;

  localparam int entryCount = 8;
  localparam int tagWidth = 8;
  localparam int dataWidth = 128;
  localparam int bankCount = 4;
  localparam int bankWidth = dataWidth / bankCount;
  localparam int byteCount = dataWidth / 8;

  typedef enum logic [2:0] {
    size8,
    size16,
    size32,
    size64,
    size80,
    size128
  } opSize_e;

  typedef enum logic [1:0] {
    entryFree,
    entryWait,
    entryReady
  } entryState_e;

  // match descriptor of one forwarding source
  typedef struct packed {
    logic has;
    logic byBank;
    logic exact;
    logic [bankCount-1:0] banks;
    logic [4:0] shift;  // bit 4 set = left, low bits in bytes
  } fwdSrc_t;

  typedef struct packed {
    opSize_e size;
    fwdSrc_t srcA;
    fwdSrc_t srcB;
    logic [tagWidth-1:0] tagA;
    logic [tagWidth-1:0] tagB;
    logic rdyA;
    logic rdyB;
    logic [dataWidth-1:0] dataA;
    logic [dataWidth-1:0] dataB;
  } fwdReq_t;

  typedef struct packed {
    logic en;
    logic [tagWidth-1:0] tag;
    logic [dataWidth-1:0] data;
  } wakeup_t;

  typedef struct packed {
    opSize_e size;
    fwdSrc_t srcA;
    fwdSrc_t srcB;
    logic [dataWidth-1:0] dataA;
    logic [dataWidth-1:0] dataB;
  } fwdPayload_t;

  // byte lanes covered by a load of the given size
  function automatic logic [byteCount-1:0] sizeMask(opSize_e size);
    case (size)
      size8: return 16'h0001;
      size16: return 16'h0003;
      size32: return 16'h000f;
      size64: return 16'h00ff;
      size80: return 16'h03ff;
      size128: return 16'hffff;
      default: return '0;
    endcase
  endfunction

  function automatic logic srcNeeded(fwdSrc_t src);
    return src.has && (src.byBank || src.exact);
  endfunction

  // banks taken from source A, the rest come from B
  function automatic logic [bankCount-1:0] bankPick(fwdSrc_t srcA);
    if (srcA.exact) return '1;
    if (srcA.byBank) return srcA.banks;
    return '0;
  endfunction

endpackage

`default_nettype wire

// ==== dv/lsfUnitTb.sv ====
`timescale 1ns/10ps
`default_nettype none

module lsfUnitTb import lsfPkg::*; ();

  localparam int randCount = 24;
  localparam int itemCount = randCount + entryCount + 5;
  localparam int limitCycles = 40 * itemCount + 100;

  logic clk = 1'b0;
  logic rst;
  logic except;
  logic newEn;
  logic outEn;
  fwdReq_t newReq;
  wakeup_t wakeup;
  logic full;
  logic outValid;
  logic [dataWidth-1:0] outData;
  logic [bankCount-1:0] outBnRead;
  int checks;
  int errors;
  fwdReq_t fillReqs [entryCount];

  lsfUnit lsfUnit_i (
    .clk(clk),
    .rst(rst),
    .except(except),
    .newEn(newEn),
    .newReq(newReq),
    .wakeup(wakeup),
    .outEn(outEn),
    .full(full),
    .outValid(outValid),
    .outData(outData),
    .outBnRead(outBnRead)
  );

  bind lsfUnit lsfUnitProperties props_i (
    .clk(clk),
    .rst(rst),
    .except(except),
    .newEn(newEn),
    .outEn(outEn),
    .full(full),
    .outValid(outValid),
    .outData(outData)
  );

  always #2 clk = ~clk;

  function automatic logic [dataWidth-1:0] randWord();
    return {$urandom, $urandom, $urandom, $urandom};
  endfunction

  function automatic fwdSrc_t randSrc();
    logic [31:0] v;
    v = $urandom;
    return fwdSrc_t'(v[$bits(fwdSrc_t)-1:0]);
  endfunction

  function automatic logic needsData(fwdSrc_t s);
    return s.has && (s.byBank || s.exact);
  endfunction

  // both sources ready or not needed
  function automatic fwdReq_t randReq();
    fwdReq_t r;
    logic [31:0] v;
    v = $urandom % 6;
    r.size = opSize_e'(v[2:0]);
    r.srcA = randSrc();
    r.srcB = randSrc();
    v = $urandom;
    r.tagA = v[7:0];
    r.tagB = ~v[7:0];  // tags never collide
    r.rdyA = needsData(r.srcA) ? 1'b1 : v[8];
    r.rdyB = needsData(r.srcB) ? 1'b1 : v[9];
    r.dataA = randWord();
    r.dataB = randWord();
    return r;
  endfunction

  function automatic fwdReq_t pendingReq(logic onB);
    fwdReq_t r;
    r = randReq();
    if (onB) begin
      r.srcA.exact = 1'b0;
      r.srcA.byBank = 1'b0;  // every bank from B
      r.srcB.has = 1'b1;
      r.srcB.byBank = 1'b1;
      r.srcB.shift = '0;
      r.rdyB = 1'b0;
    end else begin
      r.srcA.has = 1'b1;
      r.srcA.exact = 1'b1;
      r.srcA.shift = '0;
      r.rdyA = 1'b0;
    end
    return r;
  endfunction

  function automatic int sizeBytes(opSize_e size);
    case (size)
      size8: return 1;
      size16: return 2;
      size32: return 4;
      size64: return 8;
      size80: return 10;
      default: return 16;
    endcase
  endfunction

  // expected merge result from the forwarding rules
  function automatic logic [dataWidth-1:0] modelData(fwdReq_t r);
    logic [dataWidth-1:0] a;
    logic [dataWidth-1:0] b;
    logic [dataWidth-1:0] res;
    int n;
    n = 8 * int'(r.srcA.shift[3:0]);
    a = r.srcA.shift[4] ? r.dataA << n : r.dataA >> n;
    n = 8 * int'(r.srcB.shift[3:0]);
    b = r.srcB.shift[4] ? r.dataB << n : r.dataB >> n;
    for (int t = 0; t < bankCount; t++) begin
      if (r.srcA.exact || (r.srcA.byBank && r.srcA.banks[t])) begin
        res[32*t +: 32] = a[32*t +: 32];
      end else begin
        res[32*t +: 32] = b[32*t +: 32];
      end
    end
    for (int k = 0; k < 16; k++) begin
      if (k >= sizeBytes(r.size)) res[8*k +: 8] = 8'h00;
    end
    return res;
  endfunction

  function automatic logic [bankCount-1:0] modelBnRead(fwdReq_t r);
    logic [bankCount-1:0] m;
    m = '0;
    if (r.srcA.byBank && r.srcB.byBank && r.srcB.has) m = ~(r.srcA.banks | r.srcB.banks);
    if (r.srcA.byBank && !r.srcB.has) m = ~r.srcA.banks;
    if (!r.srcA.exact && !r.srcA.byBank) m = 4'hf;
    return m;
  endfunction

  task automatic expectEq(string name, logic [dataWidth-1:0] exp, logic [dataWidth-1:0] act);
    checks++;
    assert (act === exp) else begin
      errors++;
      $display("Mismatch %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic checkFlags(logic expValid, logic expFull);
    expectEq("outValid", dataWidth'(expValid), dataWidth'(outValid));
    expectEq("full", dataWidth'(expFull), dataWidth'(full));
  endtask

  task automatic checkOut(fwdReq_t r);
    expectEq("outValid", dataWidth'(1'b1), dataWidth'(outValid));
    expectEq("outData", modelData(r), outData);
    expectEq("outBnRead", dataWidth'(modelBnRead(r)), dataWidth'(outBnRead));
  endtask

  task automatic allocate(fwdReq_t r, logic wake, logic [dataWidth-1:0] wakeData);
    @(posedge clk);
    newEn <= 1'b1;
    newReq <= r;
    wakeup <= {wake, r.tagA, wakeData};  // same-cycle wakeup on source A
    @(posedge clk);
    newEn <= 1'b0;
    wakeup <= '0;
  endtask

  task automatic releaseOne();
    @(posedge clk);
    outEn <= 1'b1;
    @(posedge clk);
    outEn <= 1'b0;
  endtask

  task automatic runReady(fwdReq_t r, logic wake, logic [dataWidth-1:0] wakeData);
    fwdReq_t e;
    e = r;
    if (wake) e.dataA = wakeData;
    allocate(r, wake, wakeData);
    @(negedge clk);
    checkFlags(1'b0, 1'b0);
    @(negedge clk);
    checkOut(e);
    releaseOne();
  endtask

  task automatic runWakeup(logic onB);
    fwdReq_t r;
    logic [dataWidth-1:0] w;
    r = pendingReq(onB);
    w = randWord();
    allocate(r, 1'b0, '0);
    repeat (3) begin
      @(negedge clk);
      checkFlags(1'b0, 1'b0);
    end
    @(posedge clk);
    wakeup <= {1'b1, onB ? r.tagB : r.tagA, w};
    @(posedge clk);
    wakeup <= '0;
    @(negedge clk);
    checkFlags(1'b0, 1'b0);
    @(negedge clk);
    if (onB) r.dataB = w;
    else r.dataA = w;
    checkOut(r);
    releaseOne();
  endtask

  initial begin : stimulus
    fwdReq_t r;
    void'($urandom(33002));
    rst = 1'b1;
    except = 1'b0;
    newEn = 1'b0;
    outEn = 1'b0;
    newReq = '0;
    wakeup = '0;
    repeat (4) @(posedge clk);
    rst <= 1'b0;

    for (int i = 0; i < randCount; i++) runReady(randReq(), 1'b0, '0);
    runWakeup(1'b0);
    runWakeup(1'b1);
    runReady(pendingReq(1'b0), 1'b1, randWord());

    // fill with outEn low
    for (int i = 0; i < entryCount; i++) begin
      fillReqs[i] = randReq();
      allocate(fillReqs[i], 1'b0, '0);
    end
    @(negedge clk);
    checkFlags(1'b1, 1'b1);
    repeat (3) begin
      @(negedge clk);
      checkOut(fillReqs[0]);
    end
    @(posedge clk);
    outEn <= 1'b1;
    for (int i = 0; i < entryCount; i++) begin
      @(negedge clk);
      checkOut(fillReqs[i]);  // drains in allocation order
    end
    @(posedge clk);
    outEn <= 1'b0;
    @(negedge clk);
    checkFlags(1'b0, 1'b0);

    r = pendingReq(1'b0);
    allocate(r, 1'b0, '0);
    allocate(r, 1'b0, '0);
    allocate(randReq(), 1'b0, '0);
    repeat (2) @(negedge clk);
    checkFlags(1'b1, 1'b0);
    @(posedge clk);
    except <= 1'b1;
    @(posedge clk);
    except <= 1'b0;
    @(negedge clk);
    checkFlags(1'b0, 1'b0);
    runReady(randReq(), 1'b0, '0);

    @(negedge clk);
    $display("checks %0d, mismatches %0d, assertion failures %0d",
             checks, errors, lsfUnit_i.props_i.failCount);
    if (errors == 0 && lsfUnit_i.props_i.failCount == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

  initial begin : watchdog
    repeat (limitCycles) @(posedge clk);
    $display("Timeout: the tests did not finish within %0d cycles", limitCycles);
    $display("*** FAILED ***");
    $finish;
  end

endmodule

`default_nettype wire

// ==== dv/lsfUnit_properties.sv ====
`timescale 1ns/10ps
`default_nettype none

module lsfUnitProperties import lsfPkg::*; (
  input logic clk,
  input logic rst,
  input logic except,
  input logic newEn,
  input logic outEn,
  input logic full,
  input logic outValid,
  input logic [dataWidth-1:0] outData
);

  int occupied;
  int failCount;

  // entries in use, tracked from port activity
  always_ff @(posedge clk) begin
    if (rst || except) begin
      occupied <= 0;
    end else begin
      occupied <= occupied + int'(newEn && !full) - int'(outEn && outValid);
    end
  end

  resetClears: assert property (@(posedge clk) rst |=> !outValid && !full)
  else begin
    failCount++;
    $error("outValid or full high after reset");
  end

  fullMatchesOccupancy: assert property (
    @(posedge clk) disable iff (rst) full == (occupied == entryCount)
  ) else begin
    failCount++;
    $error("full disagrees with the number of occupied entries");
  end

  flushClears: assert property (
    @(posedge clk) disable iff (rst) except |=> !outValid && !full
  ) else begin
    failCount++;
    $error("entries left after a flush");
  end

  idleDataZero: assert property (
    @(posedge clk) disable iff (rst) !outValid |-> outData == '0
  ) else begin
    failCount++;
    $error("outData not zero while outValid is low");
  end

endmodule

`default_nettype wire

// ==== fwdArray/fwdArray.sv ====
`timescale 1ns/10ps
`default_nettype none

module fwdArray import lsfPkg::*; (
  input logic clk,
  input logic rst,
  input logic except,
  input logic newEn,
  input logic outEn,
  input fwdReq_t newReq,
  input wakeup_t wakeup,
  output logic full,
  output logic outValid,
  output fwdPayload_t selPayload
);

  entryState_e states [entryCount];
  fwdPayload_t payloads [entryCount];

  logic [entryCount-1:0] freeVec;
  logic [entryCount-1:0] readyVec;
  logic [entryCount-1:0] allocOneHot;
  logic [entryCount-1:0] selOneHot;
  logic [entryCount-1:0] allocEn;
  logic [entryCount-1:0] releaseEn;

  // lowest set bit of each vector
  assign allocOneHot = freeVec & (~freeVec + {{(entryCount-1){1'b0}}, 1'b1});
  assign selOneHot = readyVec & (~readyVec + {{(entryCount-1){1'b0}}, 1'b1});

  assign full = ~|freeVec;
  assign outValid = |readyVec;

  assign allocEn = allocOneHot & {entryCount{newEn && !full}};
  assign releaseEn = selOneHot & {entryCount{outEn}};

  for (genvar i = 0; i < entryCount; i++) begin : gEntry
    fwdEntry entry_i (
      .clk(clk),
      .rst(rst),
      .except(except),
      .alloc(allocEn[i]),
      .releaseEn(releaseEn[i]),
      .req(newReq),
      .wakeup(wakeup),
      .state(states[i]),
      .payload(payloads[i])
    );

    assign freeVec[i] = states[i] == entryFree;
    assign readyVec[i] = states[i] == entryReady;
  end

  // one-hot mux of the selected entry
  always_comb begin
    selPayload = '0;
    for (int i = 0; i < entryCount; i++) begin
      if (selOneHot[i]) selPayload = fwdPayload_t'(selPayload | payloads[i]);
    end
  end

endmodule

`default_nettype wire

// ==== fwdArray/fwdEntry.sv ====
`timescale 1ns/10ps
`default_nettype none

module fwdEntry import lsfPkg::*; (
  input logic clk,
  input logic rst,
  input logic except,
  input logic alloc,
  input logic releaseEn,
  input fwdReq_t req,
  input wakeup_t wakeup,
  output entryState_e state,
  output fwdPayload_t payload
);

  logic rdyA;
  logic rdyB;
  logic [tagWidth-1:0] tagA;
  logic [tagWidth-1:0] tagB;
  logic newHitA;
  logic newHitB;
  logic oldHitA;
  logic oldHitB;

  // wakeup hitting the request being written this cycle
  assign newHitA = wakeup.en && wakeup.tag == req.tagA;
  assign newHitB = wakeup.en && wakeup.tag == req.tagB;

  // only a source still waiting takes late wakeup data
  assign oldHitA = wakeup.en && wakeup.tag == tagA && !rdyA && state == entryWait;
  assign oldHitB = wakeup.en && wakeup.tag == tagB && !rdyB && state == entryWait;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= entryFree;
      rdyA <= 1'b0;
      rdyB <= 1'b0;
    end else if (except) begin
      state <= entryFree;
      rdyA <= 1'b0;
      rdyB <= 1'b0;
    end else if (alloc) begin
      state <= entryWait;
      rdyA <= req.rdyA || !srcNeeded(req.srcA) || newHitA;
      rdyB <= req.rdyB || !srcNeeded(req.srcB) || newHitB;
    end else if (releaseEn) begin
      state <= entryFree;
      rdyA <= 1'b0;
      rdyB <= 1'b0;
    end else if (state == entryWait) begin
      if (rdyA && rdyB) state <= entryReady;  // one edge after both flags
      if (oldHitA) rdyA <= 1'b1;
      if (oldHitB) rdyB <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (alloc) begin
      payload.size <= req.size;
      payload.srcA <= req.srcA;
      payload.srcB <= req.srcB;
      tagA <= req.tagA;
      tagB <= req.tagB;
      payload.dataA <= newHitA ? wakeup.data : req.dataA;
      payload.dataB <= newHitB ? wakeup.data : req.dataB;
    end else begin
      if (oldHitA) payload.dataA <= wakeup.data;
      if (oldHitB) payload.dataB <= wakeup.data;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/fwdMerge.sv ====
`timescale 1ns/10ps
`default_nettype none

module fwdMerge import lsfPkg::*; (
  input fwdPayload_t payload,
  input logic outValid,
  output logic [dataWidth-1:0] outData,
  output logic [bankCount-1:0] outBnRead
);

  logic [dataWidth-1:0] shA;
  logic [dataWidth-1:0] shB;
  logic [dataWidth-1:0] merged;
  logic [dataWidth-1:0] mask;
  logic [byteCount-1:0] byteMask;
  logic [bankCount-1:0] pickA;

  // byte shift of one source word
  function automatic logic [dataWidth-1:0] shiftSrc(fwdSrc_t src, logic [dataWidth-1:0] data);
    logic [6:0] bits;
    bits = {src.shift[3:0], 3'b000};
    if (src.shift[4]) return data << bits;
    return data >> bits;
  endfunction

  assign shA = shiftSrc(payload.srcA, payload.dataA);
  assign shB = shiftSrc(payload.srcB, payload.dataB);

  assign pickA = bankPick(payload.srcA);
  assign byteMask = sizeMask(payload.size);

  always_comb begin
    for (int t = 0; t < bankCount; t++) begin
      merged[t*bankWidth +: bankWidth] = pickA[t] ? shA[t*bankWidth +: bankWidth]
                                                  : shB[t*bankWidth +: bankWidth];
    end
  end

  always_comb begin
    for (int b = 0; b < byteCount; b++) begin
      mask[b*8 +: 8] = {8{byteMask[b]}};
    end
  end

  assign outData = outValid ? (merged & mask) : '0;

  // later cases win
  always_comb begin
    outBnRead = '0;
    if (payload.srcA.byBank && payload.srcB.byBank && payload.srcB.has) begin
      outBnRead = ~(payload.srcA.banks | payload.srcB.banks);
    end
    if (payload.srcA.byBank && !payload.srcB.has) begin
      outBnRead = ~payload.srcA.banks;
    end
    if (!payload.srcA.exact && !payload.srcA.byBank) begin
      outBnRead = '1;  // nothing forwarded from A, read every bank
    end
  end

endmodule

`default_nettype wire

// ==== hdl/lsfUnit.sv ====
`timescale 1ns/10ps
`default_nettype none

module lsfUnit import lsfPkg::*; (
  input logic clk,
  input logic rst,
  input logic except,
  input logic newEn,
  input fwdReq_t newReq,
  input wakeup_t wakeup,
  input logic outEn,
  output logic full,
  output logic outValid,
  output logic [dataWidth-1:0] outData,
  output logic [bankCount-1:0] outBnRead
);

  fwdPayload_t selPayload;

  fwdArray array_i (
    .clk(clk),
    .rst(rst),
    .except(except),
    .newEn(newEn),
    .outEn(outEn),
    .newReq(newReq),
    .wakeup(wakeup),
    .full(full),
    .outValid(outValid),
    .selPayload(selPayload)
  );

  fwdMerge merge_i (
    .payload(selPayload),
    .outValid(outValid),
    .outData(outData),
    .outBnRead(outBnRead)
  );

endmodule

`default_nettype wire

// ==== vlog.f ====
common/lsfPkg.sv
fwdArray/fwdEntry.sv
fwdArray/fwdArray.sv
hdl/fwdMerge.sv
hdl/lsfUnit.sv
dv/lsfUnit_properties.sv
dv/lsfUnitTb.sv
